/* id_pkg.sv */
`default_nettype none

package id_pkg;

    // Instruction word and the fields carved out of it
    typedef logic [23:0] instr_t;
    typedef logic [7:0]  opc_t;
    typedef logic [3:0]  opclass_t;
    typedef logic [3:0]  gp_idx_t;
    typedef logic [1:0]  sr_idx_t;
    typedef logic [3:0]  cc_t;

    // Immediate widths used by the encodings
    typedef logic [9:0]  imm10_t;
    typedef logic [11:0] imm12_t;
    typedef logic [13:0] imm14_t;
    typedef logic [15:0] imm16_t;

    // Special register indices
    localparam sr_idx_t SR_LR = 2'd1;
    localparam sr_idx_t SR_FL = 2'd2;

    // Opcode classes, upper nibble of the opcode
    localparam opclass_t OPCLASS_UR  = 4'h0;
    localparam opclass_t OPCLASS_UI  = 4'h1;
    localparam opclass_t OPCLASS_SR  = 4'h2;
    localparam opclass_t OPCLASS_SI  = 4'h3;
    localparam opclass_t OPCLASS_BR  = 4'h7;
    localparam opclass_t OPCLASS_SPR = 4'hF;

    // Class 0, unsigned register ops
    localparam opc_t OPC_MOVUR   = 8'h00;
    localparam opc_t OPC_ADDUR   = 8'h01;
    localparam opc_t OPC_SUBUR   = 8'h02;
    localparam opc_t OPC_CMPUR   = 8'h03;
    localparam opc_t OPC_TSTUR   = 8'h04;

    // Class 1, unsigned immediate ops
    localparam opc_t OPC_MOVUI   = 8'h10;
    localparam opc_t OPC_ADDUI   = 8'h11;
    localparam opc_t OPC_CMPUI   = 8'h12;

    // Class 2, signed register ops
    localparam opc_t OPC_ADDSR   = 8'h20;
    localparam opc_t OPC_SUBSR   = 8'h21;
    localparam opc_t OPC_CMPSR   = 8'h22;

    // Class 3, signed immediate ops
    localparam opc_t OPC_MOVSI   = 8'h30;
    localparam opc_t OPC_ADDSI   = 8'h31;
    localparam opc_t OPC_SUBSI   = 8'h32;

    // Class 7, branches and conditional move
    localparam opc_t OPC_JCCUI   = 8'h70;
    localparam opc_t OPC_BCCSR   = 8'h71;
    localparam opc_t OPC_BCCSO   = 8'h72;
    localparam opc_t OPC_BALSO   = 8'h73;
    localparam opc_t OPC_MCCUR   = 8'h74;

    // Class F, special register ops
    localparam opc_t OPC_SRMOVUR = 8'hF0;
    localparam opc_t OPC_SRADDSI = 8'hF1;
    localparam opc_t OPC_SRJCCSO = 8'hF2;
    localparam opc_t OPC_SYSCALL = 8'hF3;
    localparam opc_t OPC_KRET    = 8'hF4;

endpackage

`default_nettype wire

/* id_decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface id_decode_if;
    import id_pkg::*;

    // Presence, write-enable and signedness flags
    logic sgn_en;
    logic imm_en;
    logic has_src_gp;
    logic tgt_gp_we;
    logic has_tgt_gp;
    logic has_src_sr;
    logic tgt_sr_we;
    logic has_tgt_sr;
    logic uses_flags;

    // Extracted fields
    imm10_t  imm10;
    imm12_t  imm12;
    imm14_t  imm14;
    imm16_t  imm16;
    cc_t     cc;
    gp_idx_t src_gp;
    gp_idx_t tgt_gp;
    sr_idx_t src_sr;
    sr_idx_t tgt_sr;

    modport classifier (
        output sgn_en, imm_en, has_src_gp, tgt_gp_we, has_tgt_gp,
        output has_src_sr, tgt_sr_we, has_tgt_sr, uses_flags
    );

    modport extractor (
        input  sgn_en, imm_en, has_src_gp, tgt_gp_we, has_tgt_gp,
        input  has_src_sr, tgt_sr_we, has_tgt_sr, uses_flags,
        output imm10, imm12, imm14, imm16, cc, src_gp, tgt_gp, src_sr, tgt_sr
    );

    modport latch (
        input sgn_en, imm_en, has_src_gp, tgt_gp_we, has_tgt_gp,
        input has_src_sr, tgt_sr_we, has_tgt_sr, uses_flags,
        input imm10, imm12, imm14, imm16, cc, src_gp, tgt_gp, src_sr, tgt_sr
    );

endinterface

`default_nettype wire

/* id_opcode_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module id_opcode_classifier (
    input  id_pkg::instr_t    instr,
    id_decode_if.classifier   dec
);
    import id_pkg::*;

    opc_t       opc;
    opclass_t   opclass;
    logic [3:0] subop;
    logic       op_valid;
    logic       cls_ui;
    logic       cls_sr;
    logic       cls_si;
    logic       tgt_gp_we;
    logic       tgt_sr_we;
    logic       uses_flags;

    assign opc     = instr[23:16];
    assign opclass = opc[7:4];
    assign subop   = opc[3:0];

    // Only the low sub-opcodes of each populated class are defined
    always_comb begin
        case (opclass)
            OPCLASS_UR, OPCLASS_BR, OPCLASS_SPR: op_valid = (subop <= 4'h4);
            OPCLASS_UI, OPCLASS_SR, OPCLASS_SI:  op_valid = (subop <= 4'h2);
            default:                             op_valid = 1'b0;
        endcase
    end

    // Whole-class tests, gated so holes in a class decode to nothing
    assign cls_ui = op_valid && (opclass == OPCLASS_UI);
    assign cls_sr = op_valid && (opclass == OPCLASS_SR);
    assign cls_si = op_valid && (opclass == OPCLASS_SI);

    assign dec.sgn_en = cls_sr || cls_si ||
                        (opc == OPC_BCCSR)   || (opc == OPC_BCCSO) ||
                        (opc == OPC_BALSO)   || (opc == OPC_SRJCCSO) ||
                        (opc == OPC_SRADDSI);

    assign dec.imm_en = cls_ui || cls_si ||
                        (opc == OPC_JCCUI)   || (opc == OPC_BCCSO) ||
                        (opc == OPC_BALSO)   || (opc == OPC_SRJCCSO) ||
                        (opc == OPC_SRADDSI) || (opc == OPC_SYSCALL);

    // Compares keep the target field but never write it
    assign tgt_gp_we = (opc == OPC_MOVUR) || (opc == OPC_ADDUR) || (opc == OPC_SUBUR) ||
                       (cls_ui && (opc != OPC_CMPUI)) ||
                       (cls_sr && (opc != OPC_CMPSR)) ||
                       cls_si || (opc == OPC_MCCUR);

    assign dec.tgt_gp_we  = tgt_gp_we;
    assign dec.has_tgt_gp = tgt_gp_we ||
                            (opc == OPC_CMPUR) || (opc == OPC_TSTUR) ||
                            (opc == OPC_CMPUI) || (opc == OPC_CMPSR) ||
                            (opc == OPC_BCCSR);

    assign dec.has_src_gp = (opc == OPC_MOVUR) || (opc == OPC_ADDUR) ||
                            (opc == OPC_SUBUR) || (opc == OPC_CMPUR) ||
                            cls_sr || (opc == OPC_MCCUR);

    // Flag consumers read SR[FL] implicitly
    assign uses_flags = (opc == OPC_JCCUI) || (opc == OPC_BCCSR) || (opc == OPC_BCCSO) ||
                        (opc == OPC_BALSO) || (opc == OPC_SRJCCSO) || (opc == OPC_MCCUR);

    assign dec.uses_flags = uses_flags;
    assign dec.has_src_sr = (opc == OPC_SRMOVUR) || (opc == OPC_SRJCCSO) || uses_flags;

    // SYSCALL writes the return address into LR
    assign tgt_sr_we = (opc == OPC_SRMOVUR) || (opc == OPC_SRADDSI) || (opc == OPC_SYSCALL);

    assign dec.tgt_sr_we  = tgt_sr_we;
    assign dec.has_tgt_sr = tgt_sr_we || (opc == OPC_SRJCCSO);

endmodule

`default_nettype wire

/* id_field_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module id_field_extract (
    input  id_pkg::instr_t    instr,
    id_decode_if.extractor    dec
);
    import id_pkg::*;

    opc_t    opc;
    imm10_t  imm10;
    imm12_t  imm12;
    imm14_t  imm14;
    imm16_t  imm16;
    cc_t     cc;
    sr_idx_t tgt_sr;
    sr_idx_t src_sr;

    assign opc = instr[23:16];

    // One immediate width per opcode, the others stay zero
    always_comb begin
        imm10 = '0;
        imm12 = '0;
        imm14 = '0;
        imm16 = '0;
        case (opc)
            OPC_MOVUI, OPC_ADDUI, OPC_CMPUI,
            OPC_MOVSI, OPC_ADDSI, OPC_SUBSI,
            OPC_JCCUI, OPC_BCCSO, OPC_SYSCALL: begin
                imm12 = instr[11:0];
            end
            OPC_SRADDSI: begin
                imm14 = instr[13:0];
            end
            OPC_SRJCCSO: begin
                imm10 = instr[9:0];
            end
            OPC_BALSO: begin
                imm16 = instr[15:0];
            end
            default: begin
                imm12 = '0;
            end
        endcase
    end

    // Condition code position differs per encoding
    always_comb begin
        case (opc)
            OPC_JCCUI, OPC_BCCSO: cc = instr[15:12];
            OPC_BCCSR:            cc = instr[11:8];
            OPC_SRJCCSO:          cc = instr[13:10];
            OPC_MCCUR:            cc = instr[7:4];
            default:              cc = '0;
        endcase
    end

    // LR is implied by SYSCALL and KRET regardless of the encoded bits
    always_comb begin
        if ((opc == OPC_SYSCALL) || (opc == OPC_KRET)) begin
            tgt_sr = SR_LR;
        end else if (dec.has_tgt_sr) begin
            tgt_sr = instr[15:14];
        end else begin
            tgt_sr = '0;
        end
    end

    // Flag consumers always read FL
    always_comb begin
        if (dec.uses_flags) begin
            src_sr = SR_FL;
        end else if (dec.has_src_sr) begin
            src_sr = instr[13:12];
        end else begin
            src_sr = '0;
        end
    end

    assign dec.imm10  = imm10;
    assign dec.imm12  = imm12;
    assign dec.imm14  = imm14;
    assign dec.imm16  = imm16;
    assign dec.cc     = cc;
    assign dec.tgt_sr = tgt_sr;
    assign dec.src_sr = src_sr;

    // GP indices only when the field is present
    assign dec.tgt_gp = dec.has_tgt_gp ? instr[15:12] : '0;
    assign dec.src_gp = dec.has_src_gp ? instr[11:8]  : '0;

endmodule

`default_nettype wire

/* id_stage_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_latch #(
    parameter int ADDR_W = 16
) (
    input  logic                iw_clk,
    input  logic                iw_rst,
    input  logic                flush,
    input  logic                stall,
    input  logic [ADDR_W-1:0]   pc_in,
    input  id_pkg::instr_t      instr_in,
    id_decode_if.latch          dec,
    output logic [ADDR_W-1:0]   pc_q,
    output id_pkg::instr_t      instr_q,
    output id_pkg::opc_t        opc_q,
    output logic                sgn_en,
    output logic                imm_en,
    output id_pkg::imm10_t      imm10,
    output id_pkg::imm12_t      imm12,
    output id_pkg::imm14_t      imm14,
    output id_pkg::imm16_t      imm16,
    output id_pkg::cc_t         cc,
    output logic                has_src_gp,
    output id_pkg::gp_idx_t     src_gp,
    output id_pkg::gp_idx_t     tgt_gp,
    output logic                tgt_gp_we,
    output logic                has_src_sr,
    output id_pkg::sr_idx_t     src_sr,
    output id_pkg::sr_idx_t     tgt_sr,
    output logic                tgt_sr_we
);

    // Flush overrides stall and loads a bubble
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc_q       <= '0;
            instr_q    <= '0;
            sgn_en     <= 1'b0;
            imm_en     <= 1'b0;
            imm10      <= '0;
            imm12      <= '0;
            imm14      <= '0;
            imm16      <= '0;
            cc         <= '0;
            has_src_gp <= 1'b0;
            src_gp     <= '0;
            tgt_gp     <= '0;
            tgt_gp_we  <= 1'b0;
            has_src_sr <= 1'b0;
            src_sr     <= '0;
            tgt_sr     <= '0;
            tgt_sr_we  <= 1'b0;
        end else if (flush || !stall) begin
            pc_q       <= flush ? '0   : pc_in;
            instr_q    <= flush ? '0   : instr_in;
            sgn_en     <= flush ? 1'b0 : dec.sgn_en;
            imm_en     <= flush ? 1'b0 : dec.imm_en;
            imm10      <= flush ? '0   : dec.imm10;
            imm12      <= flush ? '0   : dec.imm12;
            imm14      <= flush ? '0   : dec.imm14;
            imm16      <= flush ? '0   : dec.imm16;
            cc         <= flush ? '0   : dec.cc;
            has_src_gp <= flush ? 1'b0 : dec.has_src_gp;
            src_gp     <= flush ? '0   : dec.src_gp;
            tgt_gp     <= flush ? '0   : dec.tgt_gp;
            tgt_gp_we  <= flush ? 1'b0 : dec.tgt_gp_we;
            has_src_sr <= flush ? 1'b0 : dec.has_src_sr;
            src_sr     <= flush ? '0   : dec.src_sr;
            tgt_sr     <= flush ? '0   : dec.tgt_sr;
            tgt_sr_we  <= flush ? 1'b0 : dec.tgt_sr_we;
        end
    end

    // Opcode follows the latched instruction, so it tracks reset and flush too
    assign opc_q = instr_q[23:16];

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
    parameter int ADDR_W = 16
) (
    input  logic                iw_clk,
    input  logic                iw_rst,
    input  logic [ADDR_W-1:0]   pc,
    input  id_pkg::instr_t      instr,
    input  logic                flush,
    input  logic                stall,
    output logic [ADDR_W-1:0]   pc_q,
    output id_pkg::instr_t      instr_q,
    output id_pkg::opc_t        opc_q,
    output logic                sgn_en,
    output logic                imm_en,
    output id_pkg::imm10_t      imm10,
    output id_pkg::imm12_t      imm12,
    output id_pkg::imm14_t      imm14,
    output id_pkg::imm16_t      imm16,
    output id_pkg::cc_t         cc,
    output logic                has_src_gp,
    output id_pkg::gp_idx_t     src_gp,
    output id_pkg::gp_idx_t     tgt_gp,
    output logic                tgt_gp_we,
    output logic                has_src_sr,
    output id_pkg::sr_idx_t     src_sr,
    output id_pkg::sr_idx_t     tgt_sr,
    output logic                tgt_sr_we
);

    // Decoded bundle between the combinational decode and the stage register
    id_decode_if dec_bus ();

    id_opcode_classifier u_classifier (
        .instr (instr),
        .dec   (dec_bus)
    );

    id_field_extract u_extract (
        .instr (instr),
        .dec   (dec_bus)
    );

    id_stage_latch #(
        .ADDR_W (ADDR_W)
    ) u_latch (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .flush      (flush),
        .stall      (stall),
        .pc_in      (pc),
        .instr_in   (instr),
        .dec        (dec_bus),
        .pc_q       (pc_q),
        .instr_q    (instr_q),
        .opc_q      (opc_q),
        .sgn_en     (sgn_en),
        .imm_en     (imm_en),
        .imm10      (imm10),
        .imm12      (imm12),
        .imm14      (imm14),
        .imm16      (imm16),
        .cc         (cc),
        .has_src_gp (has_src_gp),
        .src_gp     (src_gp),
        .tgt_gp     (tgt_gp),
        .tgt_gp_we  (tgt_gp_we),
        .has_src_sr (has_src_sr),
        .src_sr     (src_sr),
        .tgt_sr     (tgt_sr),
        .tgt_sr_we  (tgt_sr_we)
    );

endmodule

`default_nettype wire

/* id_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions #(
    parameter int ADDR_W = 16
) (
    input logic                iw_clk,
    input logic                iw_rst,
    input logic                flush,
    input logic                stall,
    input logic [ADDR_W+105:0] outs,
    input id_pkg::opc_t        opc_q,
    input logic                imm_en,
    input logic                has_src_gp,
    input logic                tgt_gp_we,
    input logic                has_src_sr,
    input logic                tgt_sr_we
);
    import id_pkg::*;

    int fail_count = 0;

    // Reset and flush both leave a bubble in the stage
    a_rst_zero: assert property (@(posedge iw_clk) iw_rst |=> (outs == '0))
        else begin
            fail_count++;
            $error("stage outputs not cleared after reset");
        end

    a_flush_zero: assert property (@(posedge iw_clk) disable iff (iw_rst)
                                   flush |=> (outs == '0))
        else begin
            fail_count++;
            $error("stage outputs not cleared after flush");
        end

    a_stall_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
                                   (stall && !flush) |=> $stable(outs))
        else begin
            fail_count++;
            $error("stage outputs changed during a stall");
        end

    // A GP write always comes from a register or immediate operand
    a_gp_we: assert property (@(posedge iw_clk) disable iff (iw_rst)
                              tgt_gp_we |-> (has_src_gp || imm_en))
        else begin
            fail_count++;
            $error("GP write enable without a source operand");
        end

    a_sr_we: assert property (@(posedge iw_clk) disable iff (iw_rst)
                              tgt_sr_we |-> (has_src_sr || imm_en || (opc_q == OPC_SYSCALL)))
        else begin
            fail_count++;
            $error("SR write enable without a source operand");
        end

endmodule

bind id_stage id_stage_assertions #(
    .ADDR_W (ADDR_W)
) u_assert (
    .iw_clk     (iw_clk),
    .iw_rst     (iw_rst),
    .flush      (flush),
    .stall      (stall),
    .outs       ({pc_q, instr_q, opc_q, sgn_en, imm_en, imm10, imm12, imm14, imm16, cc,
                  has_src_gp, src_gp, tgt_gp, tgt_gp_we, has_src_sr, src_sr, tgt_sr,
                  tgt_sr_we}),
    .opc_q      (opc_q),
    .imm_en     (imm_en),
    .has_src_gp (has_src_gp),
    .tgt_gp_we  (tgt_gp_we),
    .has_src_sr (has_src_sr),
    .tgt_sr_we  (tgt_sr_we)
);

`default_nettype wire

/* tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    localparam int ADDR_W      = 16;
    localparam int CLK_PERIOD  = 100;
    localparam int TEST_CYCLES = 16 + 3 + 24 * 4 + 16 + 8 + 300 + 2;
    localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 6 / 5;

    // Expected decoded bundle, one field per registered output
    typedef struct packed {
        logic    sgn_en;
        logic    imm_en;
        imm10_t  imm10;
        imm12_t  imm12;
        imm14_t  imm14;
        imm16_t  imm16;
        cc_t     cc;
        logic    has_src_gp;
        gp_idx_t src_gp;
        gp_idx_t tgt_gp;
        logic    tgt_gp_we;
        logic    has_src_sr;
        sr_idx_t src_sr;
        sr_idx_t tgt_sr;
        logic    tgt_sr_we;
    } dec_exp_t;

    opc_t op_table [24] = '{
        OPC_MOVUR, OPC_ADDUR, OPC_SUBUR, OPC_CMPUR, OPC_TSTUR, OPC_MOVUI, OPC_ADDUI, OPC_CMPUI,
        OPC_ADDSR, OPC_SUBSR, OPC_CMPSR, OPC_MOVSI, OPC_ADDSI, OPC_SUBSI, OPC_JCCUI, OPC_BCCSR,
        OPC_BCCSO, OPC_BALSO, OPC_MCCUR, OPC_SRMOVUR, OPC_SRADDSI, OPC_SRJCCSO, OPC_SYSCALL, OPC_KRET
    };

    logic              iw_clk;
    logic              iw_rst;
    logic [ADDR_W-1:0] pc;
    instr_t            instr;
    logic              flush;
    logic              stall;
    logic [ADDR_W-1:0] pc_q;
    instr_t            instr_q;
    opc_t              opc_q;
    logic              sgn_en;
    logic              imm_en;
    imm10_t            imm10;
    imm12_t            imm12;
    imm14_t            imm14;
    imm16_t            imm16;
    cc_t               cc;
    logic              has_src_gp;
    gp_idx_t           src_gp;
    gp_idx_t           tgt_gp;
    logic              tgt_gp_we;
    logic              has_src_sr;
    sr_idx_t           src_sr;
    sr_idx_t           tgt_sr;
    logic              tgt_sr_we;

    logic [ADDR_W-1:0] exp_pc;
    instr_t            exp_instr;
    dec_exp_t          exp_dec;
    logic [31:0]       rng_state;
    int                errors = 0;

    id_stage #(.ADDR_W(ADDR_W)) DUT (.*);

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic is_defined(input opc_t op);
        logic hit;
        hit = 1'b0;
        foreach (op_table[i]) begin
            if (op_table[i] == op)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // Reference decode written straight from the opcode rules
    function automatic dec_exp_t decode_ref(input instr_t iw);
        dec_exp_t e;
        opc_t     op;
        opclass_t cls;
        logic     flg;
        logic     has_tgt_gp;
        logic     has_tgt_sr;
        e   = '0;
        op  = iw[23:16];
        cls = op[7:4];
        if (is_defined(op)) begin
            flg = op inside {OPC_JCCUI, OPC_BCCSR, OPC_BCCSO, OPC_BALSO, OPC_SRJCCSO, OPC_MCCUR};
            e.sgn_en = (cls == 4'h2) || (cls == 4'h3) ||
                       (op inside {OPC_BCCSR, OPC_BCCSO, OPC_BALSO, OPC_SRJCCSO, OPC_SRADDSI});
            e.imm_en = (cls == 4'h1) || (cls == 4'h3) ||
                       (op inside {OPC_JCCUI, OPC_BCCSO, OPC_BALSO, OPC_SRJCCSO,
                                   OPC_SRADDSI, OPC_SYSCALL});
            e.tgt_gp_we = op inside {OPC_MOVUR, OPC_ADDUR, OPC_SUBUR, OPC_MOVUI, OPC_ADDUI,
                                     OPC_ADDSR, OPC_SUBSR, OPC_MOVSI, OPC_ADDSI, OPC_SUBSI,
                                     OPC_MCCUR};
            has_tgt_gp = e.tgt_gp_we ||
                         (op inside {OPC_CMPUR, OPC_TSTUR, OPC_CMPUI, OPC_CMPSR, OPC_BCCSR});
            e.has_src_gp = (cls == 4'h2) ||
                           (op inside {OPC_MOVUR, OPC_ADDUR, OPC_SUBUR, OPC_CMPUR, OPC_MCCUR});
            e.has_src_sr = flg || (op inside {OPC_SRMOVUR, OPC_SRJCCSO});
            e.tgt_sr_we  = op inside {OPC_SRMOVUR, OPC_SRADDSI, OPC_SYSCALL};
            has_tgt_sr   = e.tgt_sr_we || (op == OPC_SRJCCSO);
            if ((cls == 4'h1) || (cls == 4'h3) || (op inside {OPC_JCCUI, OPC_BCCSO, OPC_SYSCALL}))
                e.imm12 = iw[11:0];
            if (op == OPC_SRADDSI)
                e.imm14 = iw[13:0];
            if (op == OPC_SRJCCSO)
                e.imm10 = iw[9:0];
            if (op == OPC_BALSO)
                e.imm16 = iw[15:0];
            case (op)
                OPC_JCCUI, OPC_BCCSO: e.cc = iw[15:12];
                OPC_BCCSR:            e.cc = iw[11:8];
                OPC_SRJCCSO:          e.cc = iw[13:10];
                OPC_MCCUR:            e.cc = iw[7:4];
                default:              e.cc = '0;
            endcase
            e.tgt_gp = has_tgt_gp ? iw[15:12] : '0;
            e.src_gp = e.has_src_gp ? iw[11:8] : '0;
            if ((op == OPC_SYSCALL) || (op == OPC_KRET))
                e.tgt_sr = SR_LR;
            else if (has_tgt_sr)
                e.tgt_sr = iw[15:14];
            e.src_sr = flg ? SR_FL : (e.has_src_sr ? iw[13:12] : '0);
        end
        return e;
    endfunction

    // One cycle of expected state, same priority as the stage register
    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst || flush) begin
            exp_pc    <= '0;
            exp_instr <= '0;
            exp_dec   <= '0;
        end else if (!stall) begin
            exp_pc    <= pc;
            exp_instr <= instr;
            exp_dec   <= decode_ref(instr);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
    endtask

`define CHECK_OUT(name, sig, want) \
    assert property (@(posedge iw_clk) disable iff (iw_rst) (sig) == (want)) \
        else report_mismatch(name, 32'($sampled(sig)), 32'($sampled(want)));

    `CHECK_OUT("pc_q", pc_q, exp_pc)
    `CHECK_OUT("instr_q", instr_q, exp_instr)
    `CHECK_OUT("opc_q", opc_q, exp_instr[23:16])
    `CHECK_OUT("sgn_en", sgn_en, exp_dec.sgn_en)
    `CHECK_OUT("imm_en", imm_en, exp_dec.imm_en)
    `CHECK_OUT("imm10", imm10, exp_dec.imm10)
    `CHECK_OUT("imm12", imm12, exp_dec.imm12)
    `CHECK_OUT("imm14", imm14, exp_dec.imm14)
    `CHECK_OUT("imm16", imm16, exp_dec.imm16)
    `CHECK_OUT("cc", cc, exp_dec.cc)
    `CHECK_OUT("has_src_gp", has_src_gp, exp_dec.has_src_gp)
    `CHECK_OUT("src_gp", src_gp, exp_dec.src_gp)
    `CHECK_OUT("tgt_gp", tgt_gp, exp_dec.tgt_gp)
    `CHECK_OUT("tgt_gp_we", tgt_gp_we, exp_dec.tgt_gp_we)
    `CHECK_OUT("has_src_sr", has_src_sr, exp_dec.has_src_sr)
    `CHECK_OUT("src_sr", src_sr, exp_dec.src_sr)
    `CHECK_OUT("tgt_sr", tgt_sr, exp_dec.tgt_sr)
    `CHECK_OUT("tgt_sr_we", tgt_sr_we, exp_dec.tgt_sr_we)

`undef CHECK_OUT

    task automatic apply_cycle(input instr_t iw, input logic st, input logic fl);
        logic [31:0] r;
        @(posedge iw_clk);
        #5;
        r     = next_rand();
        pc    = r[ADDR_W-1:0];
        instr = iw;
        stall = st;
        flush = fl;
    endtask

    initial begin
        iw_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            iw_clk = ~iw_clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        instr_t      iw;
        rng_state = 32'd76171;
        iw_rst    = 1'b1;
        pc        = '0;
        instr     = '0;
        flush     = 1'b0;
        stall     = 1'b0;
        repeat (16) @(posedge iw_clk);
        #5;
        // Stalled right out of reset, outputs must stay zero
        iw_rst = 1'b0;
        stall  = 1'b1;
        instr  = {OPC_ADDUR, 16'hA5C3};
        repeat (2) apply_cycle({OPC_MOVUI, 16'h5A3C}, 1'b1, 1'b0);
        foreach (op_table[i]) begin
            repeat (4) begin
                r = next_rand();
                apply_cycle({op_table[i], r[31:16]}, 1'b0, 1'b0);
            end
        end
        // Undefined opcodes still latch pc and instr
        repeat (16) begin
            r = next_rand();
            while (is_defined(r[31:24]))
                r = next_rand();
            apply_cycle(r[31:8], 1'b0, 1'b0);
        end
        apply_cycle({OPC_SYSCALL, 16'hC3F1}, 1'b0, 1'b0);
        repeat (3) apply_cycle({OPC_BALSO, 16'hFFFF}, 1'b1, 1'b0);
        apply_cycle({OPC_MCCUR, 16'h7777}, 1'b1, 1'b1);
        apply_cycle({OPC_SRJCCSO, 16'hBEEF}, 1'b0, 1'b0);
        apply_cycle({OPC_ADDSI, 16'h0123}, 1'b0, 1'b1);
        apply_cycle({OPC_KRET, 16'h0000}, 1'b0, 1'b0);
        repeat (300) begin
            r  = next_rand();
            iw = r[3] ? {op_table[int'(r[15:8]) % 24], r[31:16]} : r[31:8];
            apply_cycle(iw, (r[5:4] == 2'b00), (r[7:5] == 3'b000));
        end
        repeat (2) @(posedge iw_clk);
        #1;
        $display("Errors: %0d output mismatches, %0d checker failures",
                 errors, DUT.u_assert.fail_count);
        if ((errors == 0) && (DUT.u_assert.fail_count == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
id_pkg.sv
id_decode_if.sv
id_opcode_classifier.sv
id_field_extract.sv
id_stage_latch.sv
id_stage.sv
id_stage_assertions.sv
tb_id_stage.sv

/* Makefile */
TOP       ?= tb_id_stage
VERILATOR ?= verilator
SEED_ARGS ?= +verilator+seed+76171
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
